//--- flist.f
src/bus_pkg.sv
src/rx_queue.sv
src/uart_port.sv
src/sram_port.sv
src/ram_uart.sv
src/ram_uart_top.sv
sim/board_model.sv
sim/tb_ram_uart.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_ram_uart -f flist.f -o sim_tb &&
./obj_dir/sim_tb || exit 1

//--- sim/tb_ram_uart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ram_uart;

	localparam int TIMEOUT = 1000;

	logic clk;
	logic rst;
	logic req_valid;
	bus_pkg::mem_req_t req;
	logic resp_valid;
	bus_pkg::mem_resp_t resp;
	logic [15:0] tx_count;
	bus_pkg::sram_ctrl_t sram;
	bus_pkg::uart_ctrl_t uart;
	bus_pkg::addr_t bus_addr;
	bus_pkg::word_t bus_out;
	logic bus_drive;
	bus_pkg::word_t bus_in;
	logic data_ready;
	logic tbre;
	logic tsre;

	// Reference model
	bus_pkg::word_t shadow [bus_pkg::addr_t];
	bus_pkg::byte_t rx_ref [$];
	int tx_sent;

	ram_uart_top ram_uart_top_i (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.resp_valid (resp_valid),
		.resp       (resp),
		.tx_count   (tx_count),
		.sram       (sram),
		.uart       (uart),
		.bus_addr   (bus_addr),
		.bus_out    (bus_out),
		.bus_drive  (bus_drive),
		.bus_in     (bus_in),
		.data_ready (data_ready),
		.tbre       (tbre),
		.tsre       (tsre)
	);

	board_model board_i (
		.clk        (clk),
		.sram       (sram),
		.uart       (uart),
		.bus_addr   (bus_addr),
		.bus_out    (bus_out),
		.bus_drive  (bus_drive),
		.bus_in     (bus_in),
		.data_ready (data_ready),
		.tbre       (tbre),
		.tsre       (tsre)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			abort_run();
		end
	endtask

	function automatic bus_pkg::word_t expected_word(input bus_pkg::addr_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return {a[7:0], a[15:8]} ^ 16'h3C96;
	endfunction

	function automatic bus_pkg::addr_t random_addr();
		bus_pkg::addr_t a;
		a = bus_pkg::UART_ADDR;
		while (a == bus_pkg::UART_ADDR) begin
			a = bus_pkg::addr_t'($urandom);
		end
		return a;
	endfunction

	// Strobe one request and count rising edges until the response
	task automatic send_request(input logic write, input bus_pkg::addr_t a,
			input bus_pkg::word_t wd, output bus_pkg::word_t rd, output int lat);
		req_valid = 1'b1;
		req.write = write;
		req.addr = a;
		req.wdata = wd;
		@(negedge clk);
		req_valid = 1'b0;
		lat = 0;
		while (!resp_valid) begin
			if (lat >= TIMEOUT) begin
				$display("no response to the request at address %h", a);
				abort_run();
			end
			@(negedge clk);
			lat++;
		end
		rd = resp.rdata;
	endtask

	task automatic sram_access(input logic write, input bus_pkg::addr_t a,
			input bus_pkg::word_t wd, input bit timed);
		bus_pkg::word_t expected;
		bus_pkg::word_t rd;
		int lat;
		expected = write ? '0 : expected_word(a);
		send_request(write, a, wd, rd, lat);
		if (write) begin
			shadow[a] = wd;
		end
		if (timed) begin
			check_value("sram latency", 32'd4, 32'(lat));
		end
		check_value("sram response", 32'(expected), 32'(rd));
	endtask

	task automatic queue_read(input bit timed);
		bus_pkg::word_t expected;
		bus_pkg::word_t rd;
		int lat;
		expected = '0;
		if (rx_ref.size() != 0) begin
			expected = {8'h00, rx_ref.pop_front()};
		end
		send_request(1'b0, bus_pkg::UART_ADDR, '0, rd, lat);
		if (timed) begin
			check_value("queue read latency", 32'd2, 32'(lat));
		end
		check_value("queue read data", 32'(expected), 32'(rd));
	endtask

	task automatic transmit(input bus_pkg::word_t wd);
		bus_pkg::word_t rd;
		int lat;
		board_i.set_tx_delays(int'(1 + $urandom % 5), int'($urandom % 5));
		send_request(1'b1, bus_pkg::UART_ADDR, wd, rd, lat);
		tx_sent++;
		check_value("transmit response", 32'd0, 32'(rd));
		check_value("tx count", 32'(tx_sent), 32'(tx_count));
		check_value("bytes seen by uart", 32'(tx_sent), 32'(board_i.tx_total));
		check_value("transmitted byte", 32'(wd[7:0]), 32'(board_i.tx_last));
	endtask

	// Reference queue drops what arrives while it is full
	task automatic inject(input bus_pkg::byte_t b);
		board_i.inject_byte(b);
		if (rx_ref.size() < bus_pkg::QUEUE_DEPTH) begin
			rx_ref.push_back(b);
		end
	endtask

	task automatic wait_rx_pending(input int left);
		int n;
		n = 0;
		while (board_i.rx_left != left || uart.rdn !== 1'b1) begin
			if (n >= TIMEOUT) begin
				$display("receive from the UART model did not settle");
				abort_run();
			end
			@(negedge clk);
			n++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		bus_pkg::addr_t addrs [$];
		int n;
		void'($urandom(74827));
		tx_sent = 0;
		rst = 1'b0;
		req_valid = 1'b0;
		req = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// Idle state after reset
		check_value("reset sram controls", 32'h7, 32'(sram));
		check_value("reset uart controls", 32'h3, 32'(uart));
		check_value("reset bus drive", 32'd0, 32'(bus_drive));
		check_value("reset tx count", 32'd0, 32'(tx_count));

		for (int i = 0; i < 24; i++) begin
			addrs.push_back(random_addr());
			sram_access(1'b1, addrs[i], bus_pkg::word_t'($urandom), 1'b1);
		end
		foreach (addrs[i]) begin
			sram_access(1'b0, addrs[i], '0, 1'b1);
		end
		for (int i = 0; i < 8; i++) begin
			sram_access(1'b0, random_addr(), '0, 1'b1);
		end

		queue_read(1'b1);
		for (int r = 0; r < 6; r++) begin
			n = 1 + int'($urandom % 4);
			for (int i = 0; i < n; i++) begin
				inject(bus_pkg::byte_t'($urandom));
			end
			wait_rx_pending(0);
			for (int i = 0; i < n; i++) begin
				queue_read(1'b1);
			end
		end
		queue_read(1'b1);

		// Requests that land on a receive in progress
		for (int r = 0; r < 6; r++) begin
			inject(bus_pkg::byte_t'($urandom));
			inject(bus_pkg::byte_t'($urandom));
			repeat (1 + $urandom % 3) @(negedge clk);
			if (r % 2 == 0) begin
				sram_access(1'b1, random_addr(), bus_pkg::word_t'($urandom), 1'b0);
			end else begin
				sram_access(1'b0, addrs[$urandom % addrs.size()], '0, 1'b0);
			end
			queue_read(1'b0);
			wait_rx_pending(0);
			queue_read(1'b1);
		end

		// Overfill, then the chip loses what the full queue refused
		for (int i = 0; i < 20; i++) begin
			inject(bus_pkg::byte_t'($urandom));
		end
		wait_rx_pending(4);
		board_i.drop_pending();
		for (int i = 0; i < 17; i++) begin
			queue_read(1'b1);
		end

		for (int i = 0; i < 12; i++) begin
			transmit(bus_pkg::word_t'($urandom));
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/board_model.sv
`timescale 1ns/1ps
`default_nettype none

module board_model (
	input  wire                      clk,
	input  wire bus_pkg::sram_ctrl_t sram,
	input  wire bus_pkg::uart_ctrl_t uart,
	input  wire bus_pkg::addr_t      bus_addr,
	input  wire bus_pkg::word_t      bus_out,
	input  wire                      bus_drive,
	output bus_pkg::word_t           bus_in,
	output logic                     data_ready,
	output logic                     tbre,
	output logic                     tsre
);

	bus_pkg::word_t mem [65536];
	bus_pkg::byte_t rx_list [$];
	bus_pkg::byte_t rx_head;
	bus_pkg::byte_t tx_last;
	int rx_left;
	int tx_total;
	int tbre_delay;
	int tsre_delay;
	logic we_n;
	logic rdn;
	logic wrn;

	assign we_n = sram.we_n;
	assign rdn = uart.rdn;
	assign wrn = uart.wrn;

	// Power-up contents depend on every address bit
	initial begin
		bus_pkg::word_t w;
		for (int i = 0; i < 65536; i++) begin
			w = bus_pkg::word_t'(i);
			mem[i] = {w[7:0], w[15:8]} ^ 16'h3C96;
		end
		rx_head = '0;
		rx_left = 0;
		tx_total = 0;
		tx_last = '0;
		tbre_delay = 1;
		tsre_delay = 0;
		data_ready = 1'b0;
		tbre = 1'b1;
		tsre = 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// SRAM chip
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		if (!sram.en_n && !sram.oe_n) begin
			bus_in = mem[bus_addr];
		end else if (!uart.rdn) begin
			bus_in = {8'h00, rx_head};
		end else begin
			bus_in = '0;
		end
	end

	always @(posedge we_n) begin
		if (!sram.en_n && bus_drive) begin
			mem[bus_addr] = bus_out;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// UART chip
	////////////////////////////////////////////////////////////////////////////
	task automatic inject_byte(input bus_pkg::byte_t b);
		rx_list.push_back(b);
		rx_left = rx_list.size();
		rx_head = rx_list[0];
		data_ready = 1'b1;
	endtask

	// Bytes the controller never fetched are lost in the chip
	task automatic drop_pending();
		rx_list.delete();
		rx_left = 0;
		data_ready = 1'b0;
	endtask

	task automatic set_tx_delays(input int hold, input int settle);
		tbre_delay = hold;
		tsre_delay = settle;
	endtask

	// Byte leaves the holding register when rdn goes back high
	always @(posedge rdn) begin
		if (rx_list.size() != 0) begin
			void'(rx_list.pop_front());
		end
		rx_left = rx_list.size();
		data_ready = (rx_left != 0);
		if (data_ready) begin
			rx_head = rx_list[0];
		end
	end

	always @(negedge wrn) begin
		tx_last = bus_out[7:0];
		tx_total = tx_total + 1;
		tbre = 1'b0;
		tsre = 1'b0;
		// tbre stays low across at least one rising edge
		repeat (tbre_delay) @(posedge clk);
		@(negedge clk);
		tbre = 1'b1;
		repeat (tsre_delay) @(negedge clk);
		tsre = 1'b1;
	end

endmodule

`default_nettype wire

//--- src/ram_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module ram_uart_top (
	input  wire                    clk,
	input  wire                    rst,
	// Processor side
	input  wire                    req_valid,
	input  wire bus_pkg::mem_req_t req,
	output logic                   resp_valid,
	output bus_pkg::mem_resp_t     resp,
	output logic [15:0]            tx_count,
	// Board side
	output bus_pkg::sram_ctrl_t    sram,
	output bus_pkg::uart_ctrl_t    uart,
	output bus_pkg::addr_t         bus_addr,
	output bus_pkg::word_t         bus_out,
	output logic                   bus_drive,
	input  wire bus_pkg::word_t    bus_in,
	input  wire                    data_ready,
	input  wire                    tbre,
	input  wire                    tsre
);

	logic q_pop;
	logic q_empty;
	logic q_full;
	bus_pkg::byte_t q_head;
	logic sram_start;
	logic sram_write;
	logic sram_done;
	bus_pkg::word_t sram_rdata;
	logic rx_start;
	logic tx_start;
	logic rx_done;
	logic tx_done;
	bus_pkg::byte_t rx_byte;

	ram_uart ram_uart_i (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.resp_valid (resp_valid),
		.resp       (resp),
		.data_ready (data_ready),
		.q_empty    (q_empty),
		.q_full     (q_full),
		.q_head     (q_head),
		.q_pop      (q_pop),
		.sram_start (sram_start),
		.sram_write (sram_write),
		.rx_start   (rx_start),
		.tx_start   (tx_start),
		.sram_done  (sram_done),
		.rx_done    (rx_done),
		.tx_done    (tx_done),
		.sram_rdata (sram_rdata),
		.bus_addr   (bus_addr),
		.bus_out    (bus_out),
		.bus_drive  (bus_drive)
	);

	// Received bytes go straight into the queue
	rx_queue rx_queue_i (
		.clk       (clk),
		.rst       (rst),
		.push      (rx_done),
		.push_data (rx_byte),
		.pop       (q_pop),
		.head      (q_head),
		.empty     (q_empty),
		.full      (q_full)
	);

	uart_port uart_port_i (
		.clk        (clk),
		.rst        (rst),
		.rx_start   (rx_start),
		.tx_start   (tx_start),
		.bus_in     (bus_in),
		.data_ready (data_ready),
		.tbre       (tbre),
		.tsre       (tsre),
		.uart       (uart),
		.rx_done    (rx_done),
		.rx_byte    (rx_byte),
		.tx_done    (tx_done),
		.tx_count   (tx_count)
	);

	sram_port sram_port_i (
		.clk    (clk),
		.rst    (rst),
		.start  (sram_start),
		.write  (sram_write),
		.bus_in (bus_in),
		.sram   (sram),
		.done   (sram_done),
		.rdata  (sram_rdata)
	);

endmodule

`default_nettype wire

//--- src/ram_uart.sv
`timescale 1ns/1ps
`default_nettype none

module ram_uart (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   req_valid,
	input  wire bus_pkg::mem_req_t req,
	output logic                  resp_valid,
	output bus_pkg::mem_resp_t    resp,
	input  wire                   data_ready,
	input  wire                   q_empty,
	input  wire                   q_full,
	input  wire bus_pkg::byte_t   q_head,
	output logic                  q_pop,
	output logic                  sram_start,
	output logic                  sram_write,
	output logic                  rx_start,
	output logic                  tx_start,
	input  wire                   sram_done,
	input  wire                   rx_done,
	input  wire                   tx_done,
	input  wire bus_pkg::word_t   sram_rdata,
	output bus_pkg::addr_t        bus_addr,
	output bus_pkg::word_t        bus_out,
	output logic                  bus_drive
);

	typedef enum logic [2:0] {
		D_IDLE,
		D_RX,
		D_SRAM,
		D_TX,
		D_Q1,
		D_Q2
	} dstate_t;

	dstate_t state;
	logic pend;
	bus_pkg::mem_req_t pend_req;
	bus_pkg::mem_req_t cur_req;
	logic have_req;
	logic to_uart;
	bus_pkg::word_t q_word;

	// A fresh strobe is served in the same cycle it arrives
	assign cur_req = req_valid ? req : pend_req;
	assign have_req = req_valid || pend;
	assign to_uart = (cur_req.addr == bus_pkg::UART_ADDR);
	assign q_word = bus_pkg::word_t'(q_head);

	// Bus side held from the pending request
	assign bus_addr = pend_req.addr;
	assign bus_out = pend_req.wdata;
	assign sram_write = pend_req.write;

	always_ff @(posedge clk) begin
		if (req_valid) begin
			pend_req <= req;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Dispatcher FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= D_IDLE;
			pend <= 1'b0;
			resp_valid <= 1'b0;
			q_pop <= 1'b0;
			sram_start <= 1'b0;
			rx_start <= 1'b0;
			tx_start <= 1'b0;
			bus_drive <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			q_pop <= 1'b0;
			sram_start <= 1'b0;
			rx_start <= 1'b0;
			tx_start <= 1'b0;
			if (req_valid) begin
				pend <= 1'b1;
			end

			case (state)
				D_IDLE: begin
					// Receive wins over any request
					if (data_ready && !q_full) begin
						rx_start <= 1'b1;
						state <= D_RX;
					end else if (have_req) begin
						pend <= 1'b0;
						if (!to_uart) begin
							sram_start <= 1'b1;
							bus_drive <= cur_req.write;
							state <= D_SRAM;
						end else if (cur_req.write) begin
							tx_start <= 1'b1;
							bus_drive <= 1'b1;
							state <= D_TX;
						end else begin
							state <= D_Q1;
						end
					end
				end
				D_RX: begin
					if (rx_done) begin
						state <= D_IDLE;
					end
				end
				D_SRAM: begin
					if (sram_done) begin
						resp_valid <= 1'b1;
						bus_drive <= 1'b0;
						state <= D_IDLE;
					end
				end
				D_TX: begin
					if (tx_done) begin
						resp_valid <= 1'b1;
						bus_drive <= 1'b0;
						state <= D_IDLE;
					end
				end
				D_Q1: begin
					q_pop <= !q_empty;
					state <= D_Q2;
				end
				default: begin
					resp_valid <= 1'b1;
					state <= D_IDLE;
				end
			endcase
		end
	end

	// Response word is zero for writes and for an empty queue
	always_ff @(posedge clk) begin
		if (state == D_SRAM && sram_done) begin
			resp.rdata <= pend_req.write ? '0 : sram_rdata;
		end else if (state == D_TX && tx_done) begin
			resp.rdata <= '0;
		end else if (state == D_Q1) begin
			resp.rdata <= q_empty ? '0 : q_word;
		end
	end

endmodule

`default_nettype wire

//--- src/sram_port.sv
`timescale 1ns/1ps
`default_nettype none

module sram_port (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 start,
	input  wire                 write,
	input  wire bus_pkg::word_t bus_in,
	output bus_pkg::sram_ctrl_t sram,
	output logic                done,
	output bus_pkg::word_t      rdata
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_EN,
		S_ACT,
		S_REL
	} sstate_t;

	sstate_t state;
	logic wr_q;

	// Enable first, then oe_n or we_n, then release
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= S_IDLE;
			sram <= bus_pkg::SRAM_IDLE;
			done <= 1'b0;
			wr_q <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						sram.en_n <= 1'b0;
						wr_q <= write;
						state <= S_EN;
					end
				end
				S_EN: begin
					sram.oe_n <= wr_q;
					sram.we_n <= !wr_q;
					state <= S_ACT;
				end
				S_ACT: begin
					sram.oe_n <= 1'b1;
					sram.we_n <= 1'b1;
					done <= 1'b1;
					// Chip latches on the we_n rise, so en_n stays low a cycle longer
					if (wr_q) begin
						state <= S_REL;
					end else begin
						sram.en_n <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: begin
					sram.en_n <= 1'b1;
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Read data sampled while oe_n is low
	always_ff @(posedge clk) begin
		if (state == S_ACT && !wr_q) begin
			rdata <= bus_in;
		end
	end

endmodule

`default_nettype wire

//--- src/uart_port.sv
`timescale 1ns/1ps
`default_nettype none

module uart_port (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 rx_start,
	input  wire                 tx_start,
	input  wire bus_pkg::word_t bus_in,
	input  wire                 data_ready,
	input  wire                 tbre,
	input  wire                 tsre,
	output bus_pkg::uart_ctrl_t uart,
	output logic                rx_done,
	output bus_pkg::byte_t      rx_byte,
	output logic                tx_done,
	output logic [15:0]         tx_count
);

	typedef enum logic [2:0] {
		U_IDLE,
		U_RX1,
		U_RX2,
		U_TX_LOW,
		U_TX_TBRE,
		U_TX_TSRE
	} ustate_t;

	ustate_t state;

	// UART chip drives its byte on the low half while rdn is low
	assign rx_byte = bus_in[bus_pkg::BYTE_W-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Chip handshake sequencer
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= U_IDLE;
			uart <= bus_pkg::UART_IDLE;
			rx_done <= 1'b0;
			tx_done <= 1'b0;
			tx_count <= '0;
		end else begin
			rx_done <= 1'b0;
			tx_done <= 1'b0;

			// One more byte has left the shift register
			if (tx_done) begin
				tx_count <= tx_count + 1'b1;
			end

			case (state)
				U_IDLE: begin
					if (rx_start && data_ready) begin
						uart.rdn <= 1'b0;
						state <= U_RX1;
					end else if (tx_start) begin
						uart.wrn <= 1'b0;
						state <= U_TX_LOW;
					end
				end

				// rdn stays low for two cycles and the byte is taken in the second
				U_RX1: begin
					rx_done <= 1'b1;
					state <= U_RX2;
				end
				U_RX2: begin
					uart.rdn <= 1'b1;
					state <= U_IDLE;
				end

				// Hold wrn low until the chip accepts the byte
				U_TX_LOW: begin
					if (!tbre) begin
						uart.wrn <= 1'b1;
						state <= U_TX_TBRE;
					end
				end
				U_TX_TBRE: begin
					if (tbre) begin
						state <= U_TX_TSRE;
					end
				end
				U_TX_TSRE: begin
					if (tsre) begin
						tx_done <= 1'b1;
						state <= U_IDLE;
					end
				end

				default: begin
					state <= U_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/rx_queue.sv
`timescale 1ns/1ps
`default_nettype none

module rx_queue (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 push,
	input  wire bus_pkg::byte_t push_data,
	input  wire                 pop,
	output bus_pkg::byte_t      head,
	output logic                empty,
	output logic                full
);

	bus_pkg::byte_t mem [bus_pkg::QUEUE_DEPTH];
	logic [bus_pkg::QUEUE_AW-1:0] front;
	logic [bus_pkg::QUEUE_AW-1:0] tail;
	logic [bus_pkg::QUEUE_AW:0] count;
	logic do_push;
	logic do_pop;

	// Occupancy flags
	assign empty = (count == '0);
	assign full = (count == (bus_pkg::QUEUE_AW+1)'(bus_pkg::QUEUE_DEPTH));

	// Push on full and pop on empty are dropped here
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign head = mem[front];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[tail] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			front <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				tail <= tail + 1'b1;
			end
			if (do_pop) begin
				front <= front + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////////////////////
	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;
	localparam int BYTE_W = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [BYTE_W-1:0] byte_t;

	// Single address decoded as the UART
	localparam addr_t UART_ADDR = 16'hBF00;

	// Receive queue geometry
	localparam int QUEUE_AW = 4;
	localparam int QUEUE_DEPTH = 1 << QUEUE_AW;

	////////////////////////////////////////////////////////////////////////////
	// Processor side
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic  write;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		word_t rdata;
	} mem_resp_t;

	////////////////////////////////////////////////////////////////////////////
	// Chip controls, all active low
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic en_n;
		logic oe_n;
		logic we_n;
	} sram_ctrl_t;

	typedef struct packed {
		logic rdn;
		logic wrn;
	} uart_ctrl_t;

	localparam sram_ctrl_t SRAM_IDLE = '{en_n: 1'b1, oe_n: 1'b1, we_n: 1'b1};
	localparam uart_ctrl_t UART_IDLE = '{rdn: 1'b1, wrn: 1'b1};

endpackage

`default_nettype wire
